// ==== fetchFrontEnd.f ====
+incdir+src
src/fetchPkg.sv
src/fetchPcReg.sv
src/fetchCtrlRegs.sv
src/instMem.sv
src/fetchFrontEnd.sv
testbench/fetchFrontEndTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetchFrontEndTb -f fetchFrontEnd.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/VfetchFrontEndTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// ==== src/fetchConsts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// ------------------------------------------------------------
// reset and boot
// ------------------------------------------------------------

// mips boot vector in kseg1
`define START_PC        32'hBFC00000

// ------------------------------------------------------------
// exception codes
// ------------------------------------------------------------

// address error on load or instruction fetch
`define EXC_ADEL        5'd4

// ------------------------------------------------------------
// apb register map
// ------------------------------------------------------------

// byte offsets inside the register window
`define REG_CTRL        8'h00
`define REG_BOOTPC      8'h04
`define REG_WAIT        8'h08
`define REG_GROUPCNT    8'h0C
`define REG_BADVADDR    8'h10
`define REG_STATUS      8'h14

// ------------------------------------------------------------
// instruction memory model
// ------------------------------------------------------------

// one group per index value, four words each
`define MEM_GROUPS      256
`define INST_PATTERN    32'hA5000000

`endif

// ==== src/fetchCtrlRegs.sv ====
`timescale 1ns/1ps
`include "fetchConsts.svh"

module fetchCtrlRegs (
    input  logic             clk,
    input  logic             rst,
    input  fetchPkg::wordT   paddr_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  fetchPkg::wordT   pwdata_i,
    input  logic             accepted_i,
    input  logic             addrErr_i,
    input  fetchPkg::wordT   badTarget_i,
    output fetchPkg::wordT   prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    output logic             fetchEnable_o,
    output logic             bootLoad_o,
    output fetchPkg::wordT   bootPc_o,
    output fetchPkg::waitT   memWait_o
);
    import fetchPkg::*;

    regAddrT offset;
    logic    apbAccess;
    logic    regHit;
    logic    regRo;
    wordT    regRdata;
    logic    wrEn;
    wordT    groupCnt;
    wordT    badVAddr;
    logic    addrErrFlag;

    // ------------------------------------------------------------
    // apb decode
    // ------------------------------------------------------------

    assign offset    = regAddrT'(paddr_i[7:0]);
    // access phase only, no wait states
    assign apbAccess = psel_i && penable_i;

    always_comb begin
        regHit   = (paddr_i[31:8] == 24'd0);
        regRo    = 1'b0;
        regRdata = '0;
        case (offset)
            OFS_CTRL: regRdata = {31'd0, fetchEnable_o};
            OFS_BOOTPC: regRdata = bootPc_o;
            OFS_WAIT: regRdata = {29'd0, memWait_o};
            OFS_GROUPCNT: begin
                regRo    = 1'b1;
                regRdata = groupCnt;
            end
            OFS_BADVADDR: begin
                regRo    = 1'b1;
                regRdata = badVAddr;
            end
            OFS_STATUS: regRdata = {31'd0, addrErrFlag};
            default: regHit = 1'b0;
        endcase
    end

    // unmapped or read-only write is an error, write dropped
    assign wrEn      = apbAccess && pwrite_i && regHit && !regRo;
    assign pready_o  = 1'b1;
    assign pslverr_o = apbAccess && (!regHit || (pwrite_i && regRo));
    // erroneous reads return zero
    assign prdata_o  = (apbAccess && !pwrite_i && regHit) ? regRdata : '0;

    // ------------------------------------------------------------
    // writable registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            fetchEnable_o <= 1'b0;
            bootPc_o      <= `START_PC;
            memWait_o     <= '0;
            bootLoad_o    <= 1'b0;
        end else begin
            // pulse defaults low
            bootLoad_o <= 1'b0;
            if (wrEn) begin
                case (offset)
                    OFS_CTRL: fetchEnable_o <= pwdata_i[0];
                    OFS_BOOTPC: begin
                        bootPc_o   <= pwdata_i;
                        bootLoad_o <= 1'b1;
                    end
                    OFS_WAIT: memWait_o <= pwdata_i[2:0];
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // status side
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            groupCnt    <= '0;
            badVAddr    <= '0;
            addrErrFlag <= 1'b0;
        end else begin
            if (accepted_i) begin
                groupCnt <= groupCnt + 32'd1;
            end
            // new error wins over a w1c in the same cycle
            if (accepted_i && addrErr_i) begin
                badVAddr    <= badTarget_i;
                addrErrFlag <= 1'b1;
            end else if (wrEn && offset == OFS_STATUS && pwdata_i[0]) begin
                addrErrFlag <= 1'b0;
            end
        end
    end

    // boot load never stretches
    assert property (@(posedge clk) disable iff (!rst)
        bootLoad_o |=> !bootLoad_o);

endmodule

// ==== src/fetchFrontEnd.sv ====
`timescale 1ns/1ps

module fetchFrontEnd (
    input  logic                clk,
    input  logic                rst,
    // apb slave
    input  fetchPkg::wordT      paddr_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  fetchPkg::wordT      pwdata_i,
    output fetchPkg::wordT      prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    // branch and exception side
    input  logic                stopFetch_i,
    input  fetchPkg::wordT      predictPc_i,
    input  logic                needDelaySlot_i,
    input  logic                flush_i,
    input  fetchPkg::wordT      correctPc_i,
    input  logic                excOccur_i,
    input  fetchPkg::wordT      excPc_i,
    // fetch results
    output fetchPkg::wordT      vAddr_o,
    output fetchPkg::wordT      lastVAddr_o,
    output fetchPkg::instEnT    instEn_o,
    output logic                hasException_o,
    output fetchPkg::excCodeT   excCode_o,
    output logic                needDelaySlot_o,
    output logic                instReq_o,
    output fetchPkg::groupDataT rdata_o,
    output logic                rdataValid_o
);
    import fetchPkg::*;

    logic     fetchEnable;
    logic     bootLoad;
    wordT     bootPc;
    waitT     memWait;
    logic     indexOk;
    groupIdxT instIndex;
    logic     accepted;
    wordT     badTarget;

    // ------------------------------------------------------------
    // pc and request generation
    // ------------------------------------------------------------

    fetchPcReg fetchPcReg_inst (
        .clk             (clk),
        .rst             (rst),
        .fetchEnable_i   (fetchEnable),
        .bootLoad_i      (bootLoad),
        .bootPc_i        (bootPc),
        .stopFetch_i     (stopFetch_i),
        .predictPc_i     (predictPc_i),
        .needDelaySlot_i (needDelaySlot_i),
        .flush_i         (flush_i),
        .correctPc_i     (correctPc_i),
        .excOccur_i      (excOccur_i),
        .excPc_i         (excPc_i),
        .indexOk_i       (indexOk),
        .instReq_o       (instReq_o),
        .instIndex_o     (instIndex),
        .vAddr_o         (vAddr_o),
        .lastVAddr_o     (lastVAddr_o),
        .instEn_o        (instEn_o),
        .hasException_o  (hasException_o),
        .excCode_o       (excCode_o),
        .needDelaySlot_o (needDelaySlot_o),
        .accepted_o      (accepted),
        .badTarget_o     (badTarget)
    );

    // ------------------------------------------------------------
    // control registers
    // ------------------------------------------------------------

    // address error status is the pc block exception flag
    fetchCtrlRegs fetchCtrlRegs_inst (
        .clk           (clk),
        .rst           (rst),
        .paddr_i       (paddr_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .pwdata_i      (pwdata_i),
        .accepted_i    (accepted),
        .addrErr_i     (hasException_o),
        .badTarget_i   (badTarget),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .fetchEnable_o (fetchEnable),
        .bootLoad_o    (bootLoad),
        .bootPc_o      (bootPc),
        .memWait_o     (memWait)
    );

    // ------------------------------------------------------------
    // instruction memory
    // ------------------------------------------------------------

    instMem instMem_inst (
        .clk          (clk),
        .rst          (rst),
        .instReq_i    (instReq_o),
        .instIndex_i  (instIndex),
        .memWait_i    (memWait),
        .indexOk_o    (indexOk),
        .rdata_o      (rdata_o),
        .rdataValid_o (rdataValid_o)
    );

endmodule

// ==== src/fetchPcReg.sv ====
`timescale 1ns/1ps
`include "fetchConsts.svh"

module fetchPcReg (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetchEnable_i,
    input  logic               bootLoad_i,
    input  fetchPkg::wordT     bootPc_i,
    input  logic               stopFetch_i,
    input  fetchPkg::wordT     predictPc_i,
    input  logic               needDelaySlot_i,
    input  logic               flush_i,
    input  fetchPkg::wordT     correctPc_i,
    input  logic               excOccur_i,
    input  fetchPkg::wordT     excPc_i,
    input  logic               indexOk_i,
    output logic               instReq_o,
    output fetchPkg::groupIdxT instIndex_o,
    output fetchPkg::wordT     vAddr_o,
    output fetchPkg::wordT     lastVAddr_o,
    output fetchPkg::instEnT   instEn_o,
    output logic               hasException_o,
    output fetchPkg::excCodeT  excCode_o,
    output logic               needDelaySlot_o,
    output logic               accepted_o,
    output fetchPkg::wordT     badTarget_o
);
    import fetchPkg::*;

    logic    accept;
    logic    usePredict;
    wordT    target;
    wordT    alignedTarget;
    logic    misaligned;
    instEnT  posMask;
    logic    acceptedReg;

    // ------------------------------------------------------------
    // request and handshake
    // ------------------------------------------------------------

    // fetchEnable is cleared by reset in the register block
    assign instReq_o = fetchEnable_i && !stopFetch_i;
    assign accept    = instReq_o && indexOk_i;

    // ------------------------------------------------------------
    // next target selection
    // ------------------------------------------------------------

    // prediction only when nothing redirects
    assign usePredict = !(excOccur_i || flush_i);

    // exception beats mispredict beats prediction
    always_comb begin
        if (excOccur_i) begin
            target = excPc_i;
        end else if (flush_i) begin
            target = correctPc_i;
        end else begin
            target = predictPc_i;
        end
    end

    // group base, word offset bits kept for the error check
    assign alignedTarget = {target[31:4], 2'b00, target[1:0]};
    assign misaligned    = |target[1:0];

    // slots before the target are dropped
    always_comb begin
        case (target[3:2])
            2'b00: begin
                // delay slot case keeps the branch slot only
                posMask = (usePredict && needDelaySlot_i) ? 4'b0001 : 4'b1111;
            end
            2'b01: posMask = 4'b1110;
            2'b10: posMask = 4'b1100;
            default: posMask = 4'b1000;
        endcase
    end

    // ------------------------------------------------------------
    // pc state
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            instIndex_o     <= groupIdxT'(`START_PC >> 4);
            vAddr_o         <= `START_PC;
            lastVAddr_o     <= `START_PC - 32'd4;
            instEn_o        <= 4'b1111;
            hasException_o  <= 1'b0;
            excCode_o       <= '0;
            needDelaySlot_o <= 1'b0;
            badTarget_o     <= '0;
        end else if (accept) begin
            instIndex_o     <= target[11:4];
            vAddr_o         <= alignedTarget;
            lastVAddr_o     <= vAddr_o;
            // misaligned target kills the whole group
            instEn_o        <= misaligned ? 4'b0000 : posMask;
            hasException_o  <= misaligned;
            excCode_o       <= misaligned ? `EXC_ADEL : '0;
            needDelaySlot_o <= usePredict && needDelaySlot_i;
            // raw target, kept for badvaddr
            badTarget_o     <= target;
        end else if (bootLoad_i && !fetchEnable_i) begin
            // boot pc load, only while fetch is stopped
            instIndex_o     <= bootPc_i[11:4];
            vAddr_o         <= bootPc_i;
            lastVAddr_o     <= bootPc_i - 32'd4;
            instEn_o        <= 4'b1111;
            hasException_o  <= 1'b0;
            needDelaySlot_o <= 1'b0;
        end
    end

    // one cycle after acceptance, pc outputs are fresh
    always_ff @(posedge clk) begin
        if (!rst) begin
            acceptedReg <= 1'b0;
        end else begin
            acceptedReg <= accept;
        end
    end

    assign accepted_o = acceptedReg;

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // exception target wins over a simultaneous flush
    assert property (@(posedge clk) disable iff (!rst)
        (accept && excOccur_i && flush_i) |=> (vAddr_o[31:4] == $past(excPc_i[31:4])));

    // no slot enabled while an address error is reported
    assert property (@(posedge clk) disable iff (!rst)
        hasException_o |-> (instEn_o == 4'b0000));

endmodule

// ==== src/fetchPkg.sv ====
`include "fetchConsts.svh"

package fetchPkg;

    // full 32-bit word: pcs, addresses, apb data
    typedef logic [31:0] wordT;

    // slot enables, bit n for instruction n of the group
    typedef logic [3:0] instEnT;

    // group index from vaddr bits 11:4
    typedef logic [7:0] groupIdxT;

    // four instructions, slot 0 in the low word
    typedef logic [127:0] groupDataT;

    // cp0 style exception code
    typedef logic [4:0] excCodeT;

    // memory stall count
    typedef logic [2:0] waitT;

    // register offsets of the control block
    typedef enum logic [7:0] {
        OFS_CTRL     = `REG_CTRL,
        OFS_BOOTPC   = `REG_BOOTPC,
        OFS_WAIT     = `REG_WAIT,
        OFS_GROUPCNT = `REG_GROUPCNT,
        OFS_BADVADDR = `REG_BADVADDR,
        OFS_STATUS   = `REG_STATUS
    } regAddrT;

endpackage

// ==== src/instMem.sv ====
`timescale 1ns/1ps
`include "fetchConsts.svh"

module instMem (
    input  logic                clk,
    input  logic                rst,
    input  logic                instReq_i,
    input  fetchPkg::groupIdxT  instIndex_i,
    input  fetchPkg::waitT      memWait_i,
    output logic                indexOk_o,
    output fetchPkg::groupDataT rdata_o,
    output logic                rdataValid_o
);
    import fetchPkg::*;

    groupDataT romArray [`MEM_GROUPS];
    waitT      stallCnt;
    logic      accept;
    groupDataT rdataReg;
    logic      rdataValidReg;

    // ------------------------------------------------------------
    // pattern contents
    // ------------------------------------------------------------

    // word n of group g is its own byte address xor pattern
    initial begin
        for (int g = 0; g < `MEM_GROUPS; g++) begin
            for (int n = 0; n < 4; n++) begin
                romArray[g][n*32 +: 32] = (32'(g) * 32'd16 + 32'(n) * 32'd4) ^ `INST_PATTERN;
            end
        end
    end

    // ------------------------------------------------------------
    // index handshake
    // ------------------------------------------------------------

    // ready unless a stall window is running
    assign indexOk_o = (stallCnt == '0);
    assign accept    = instReq_i && indexOk_o;

    // stall counter reloads on every acceptance
    always_ff @(posedge clk) begin
        if (!rst) begin
            stallCnt <= '0;
        end else if (accept) begin
            stallCnt <= memWait_i;
        end else if (stallCnt != '0) begin
            stallCnt <= stallCnt - 3'd1;
        end
    end

    // ------------------------------------------------------------
    // read path
    // ------------------------------------------------------------

    // data register, one group per acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            rdataReg <= romArray[instIndex_i];
        end
    end

    // valid for a single cycle only
    always_ff @(posedge clk) begin
        if (!rst) begin
            rdataValidReg <= 1'b0;
        end else begin
            rdataValidReg <= accept;
        end
    end

    assign rdata_o      = rdataReg;
    assign rdataValid_o = rdataValidReg;

    // every valid beat comes with the stall window its acceptance loaded
    assert property (@(posedge clk) disable iff (!rst)
        rdataValid_o |-> (stallCnt == $past(memWait_i)));

endmodule

// ==== testbench/fetchFrontEndTb.sv ====
`timescale 1ns/1ps
`include "fetchConsts.svh"

module fetchFrontEndTb;
    import fetchPkg::*;

    localparam int VALID_TIMEOUT = 60;
    localparam int APB_TIMEOUT   = 20;

    logic      clk;
    logic      rst;
    wordT      paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    wordT      pwdata;
    wordT      prdata;
    logic      pready;
    logic      pslverr;
    logic      stopFetch;
    wordT      predictPc;
    logic      needDelaySlot;
    logic      flush;
    wordT      correctPc;
    logic      excOccur;
    wordT      excPc;
    wordT      vAddr;
    wordT      lastVAddr;
    instEnT    instEn;
    logic      hasException;
    excCodeT   excCode;
    logic      needDelaySlotOut;
    logic      instReq;
    groupDataT rdata;
    logic      rdataValid;

    int        checkCount;
    int        errorCount;
    int        testCount;
    int        testErrStart;
    int        validCount;
    groupIdxT  trackIdx;

    fetchFrontEnd fetchFrontEnd_inst (
        .clk             (clk),
        .rst             (rst),
        .paddr_i         (paddr),
        .psel_i          (psel),
        .penable_i       (penable),
        .pwrite_i        (pwrite),
        .pwdata_i        (pwdata),
        .prdata_o        (prdata),
        .pready_o        (pready),
        .pslverr_o       (pslverr),
        .stopFetch_i     (stopFetch),
        .predictPc_i     (predictPc),
        .needDelaySlot_i (needDelaySlot),
        .flush_i         (flush),
        .correctPc_i     (correctPc),
        .excOccur_i      (excOccur),
        .excPc_i         (excPc),
        .vAddr_o         (vAddr),
        .lastVAddr_o     (lastVAddr),
        .instEn_o        (instEn),
        .hasException_o  (hasException),
        .excCode_o       (excCode),
        .needDelaySlot_o (needDelaySlotOut),
        .instReq_o       (instReq),
        .rdata_o         (rdata),
        .rdataValid_o    (rdataValid)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // reference model of the fetch rules
    // ------------------------------------------------------------

    // group g, word n holds its byte address xor the pattern
    function automatic groupDataT patternFor(groupIdxT g);
        groupDataT d;
        for (int n = 0; n < 4; n++) begin
            d[n*32 +: 32] = ({24'd0, g} * 32'd16 + n * 4) ^ `INST_PATTERN;
        end
        return d;
    endfunction

    // slots before the target dropped, delay slot keeps slot 0 only
    function automatic instEnT maskFor(wordT pc, logic delaySlot);
        if (pc[1:0] != 2'b00) begin
            return 4'b0000;
        end
        case (pc[3:2])
            2'b00: return delaySlot ? 4'b0001 : 4'b1111;
            2'b01: return 4'b1110;
            2'b10: return 4'b1100;
            default: return 4'b1000;
        endcase
    endfunction

    function automatic wordT groupBase(wordT pc);
        return pc & ~32'h0000000C;
    endfunction

    // group index presented next, exception before flush before prediction
    function automatic groupIdxT targetIndex(logic exc, logic fl, wordT excAddr,
                                             wordT corrAddr, wordT predAddr);
        wordT t;
        if (exc) begin
            t = excAddr;
        end else if (fl) begin
            t = corrAddr;
        end else begin
            t = predAddr;
        end
        return t[11:4];
    endfunction

    function automatic wordT randAligned();
        return $urandom & 32'hFFFFFFFC;
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------

    task automatic checkWord(wordT act, wordT exp, string what);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic checkEn(instEnT act, instEnT exp, string what);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic checkCode(excCodeT act, excCodeT exp, string what);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic checkGroup(groupDataT act, groupDataT exp, string what);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    task automatic checkBool(logic act, logic exp, string what);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    // ------------------------------------------------------------
    // run control
    // ------------------------------------------------------------

    task automatic abortRun(string reason);
        $display("ERROR: %s", reason);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic startTest();
        testErrStart = errorCount;
        testCount++;
    endtask

    task automatic endTest(string name);
        int errs;
        errs = errorCount - testErrStart;
        if (errs == 0) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            $display("test %0d %s: %0d errors", testCount, name, errs);
        end
    endtask

    // one clock, then into the drive slot
    task automatic step(int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // returns in the drive slot of the edge that raised rdataValid
    task automatic waitValid(string what);
        int cycles;
        cycles = 0;
        step(1);
        while (!rdataValid) begin
            if (cycles == VALID_TIMEOUT) begin
                abortRun({"no read data arrived while waiting for ", what});
            end
            step(1);
            cycles++;
        end
    endtask

    // ------------------------------------------------------------
    // apb master
    // ------------------------------------------------------------

    task automatic apbTransfer(wordT addr, logic write, wordT wdata,
                               output wordT rdataOut, output logic err);
        int cycles;
        cycles  = 0;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        step(1);
        penable = 1'b1;
        #1;
        while (!pready) begin
            if (cycles == APB_TIMEOUT) begin
                abortRun("APB slave never raised pready");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        rdataOut = prdata;
        err      = pslverr;
        step(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbWrite(wordT addr, wordT data, output logic err);
        wordT unused;
        apbTransfer(addr, 1'b1, data, unused, err);
    endtask

    task automatic apbRead(wordT addr, output wordT data, output logic err);
        apbTransfer(addr, 1'b0, '0, data, err);
    endtask

    // ------------------------------------------------------------
    // read data monitor
    // ------------------------------------------------------------

    // each beat carries the group presented at its acceptance
    always @(posedge clk) begin
        #1;
        if (rst && rdataValid) begin
            validCount++;
            checkGroup(rdata, patternFor(trackIdx), "streamed group");
            // inputs still hold what the accepting edge saw
            trackIdx = targetIndex(excOccur, flush, excPc, correctPc, predictPc);
        end
    end

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------

    task automatic testResetBoot();
        wordT bootPc;
        logic err;
        startTest();
        bootPc = 32'hBFC00120;
        checkBool(instReq, 1'b0, "instReq after reset");
        checkWord(vAddr, `START_PC, "vAddr after reset");
        predictPc = bootPc + 32'd16;
        apbWrite(wordT'(`REG_BOOTPC), bootPc, err);
        step(1);
        checkWord(vAddr, bootPc, "vAddr after boot load");
        checkWord(lastVAddr, bootPc - 32'd4, "lastVAddr after boot load");
        trackIdx = bootPc[11:4];
        apbWrite(wordT'(`REG_CTRL), 32'd1, err);
        waitValid("boot group");
        checkGroup(rdata, patternFor(bootPc[11:4]), "boot group data");
        endTest("reset and boot");
    endtask

    task automatic testPredicted();
        wordT pc;
        startTest();
        for (int i = 0; i < 10; i++) begin
            pc = randAligned();
            // every third pass forces a delay slot at slot 0
            needDelaySlot = (i % 3 == 0);
            if (needDelaySlot) begin
                pc = groupBase(pc);
            end
            predictPc = pc;
            waitValid("predicted group");
            checkWord(vAddr, groupBase(pc), "predicted vAddr");
            checkEn(instEn, maskFor(pc, needDelaySlot), "predicted instEn");
            checkBool(needDelaySlotOut, needDelaySlot, "delay slot flag");
        end
        needDelaySlot = 1'b0;
        endTest("predicted fetch");
    endtask

    task automatic testRedirect();
        startTest();
        excPc     = 32'h80000184;
        correctPc = 32'h00400A28;
        excOccur  = 1'b1;
        flush     = 1'b1;
        waitValid("exception redirect");
        checkWord(vAddr, groupBase(excPc), "vAddr on exception plus flush");
        checkEn(instEn, maskFor(excPc, 1'b0), "instEn on exception");
        excOccur = 1'b0;
        waitValid("flush redirect");
        checkWord(vAddr, groupBase(correctPc), "vAddr on flush");
        checkEn(instEn, maskFor(correctPc, 1'b0), "instEn on flush");
        flush = 1'b0;
        endTest("redirect priority");
    endtask

    task automatic testAlignError();
        wordT pc;
        wordT data;
        logic err;
        startTest();
        pc        = randAligned() | 32'd2;
        predictPc = pc;
        waitValid("misaligned group");
        checkBool(hasException, 1'b1, "hasException");
        checkCode(excCode, `EXC_ADEL, "excCode");
        checkEn(instEn, 4'b0000, "instEn on address error");
        apbWrite(wordT'(`REG_CTRL), 32'd0, err);
        predictPc = randAligned();
        step(3);
        apbRead(wordT'(`REG_BADVADDR), data, err);
        checkWord(data, pc, "BADVADDR");
        apbRead(wordT'(`REG_STATUS), data, err);
        checkBool(data[0], 1'b1, "STATUS addrErr set");
        apbWrite(wordT'(`REG_STATUS), 32'd1, err);
        apbRead(wordT'(`REG_STATUS), data, err);
        checkBool(data[0], 1'b0, "STATUS addrErr cleared");
        endTest("alignment error");
    endtask

    task automatic testBackPressure();
        wordT cntStart;
        wordT cntEnd;
        wordT prevV;
        wordT pc;
        waitT waitVal;
        int   validStart;
        int   stallLeft;
        logic expAccept;
        logic err;
        startTest();
        apbRead(wordT'(`REG_GROUPCNT), cntStart, err);
        waitVal = waitT'($urandom % 7 + 1);
        apbWrite(wordT'(`REG_WAIT), {29'd0, waitVal}, err);
        validStart = validCount;
        apbWrite(wordT'(`REG_CTRL), 32'd1, err);
        prevV     = vAddr;
        stallLeft = 0;
        for (int i = 0; i < 50; i++) begin
            pc        = randAligned();
            predictPc = pc;
            stopFetch = ($urandom % 3 == 0);
            // memory stalls waitVal cycles after each acceptance
            expAccept = !stopFetch && (stallLeft == 0);
            if (expAccept) begin
                stallLeft = int'(waitVal);
            end else if (stallLeft != 0) begin
                stallLeft--;
            end
            step(1);
            checkBool(instReq, !stopFetch, "instReq with stopFetch");
            checkBool(rdataValid, expAccept, "rdataValid after edge");
            // pc moves only on an acceptance
            if (expAccept) begin
                checkWord(vAddr, groupBase(pc), "vAddr after acceptance");
            end else begin
                checkWord(vAddr, prevV, "vAddr while stalled");
            end
            prevV = vAddr;
        end
        stopFetch = 1'b0;
        apbWrite(wordT'(`REG_CTRL), 32'd0, err);
        step(4);
        apbRead(wordT'(`REG_GROUPCNT), cntEnd, err);
        checkWord(cntEnd - cntStart, wordT'(validCount - validStart), "groups vs GROUPCNT");
        endTest("back-pressure");
    endtask

    task automatic testApbErrors();
        wordT data;
        wordT cntBefore;
        wordT waitBefore;
        logic err;
        startTest();
        apbRead(wordT'(`REG_GROUPCNT), cntBefore, err);
        apbRead(wordT'(`REG_WAIT), waitBefore, err);
        apbWrite(32'h00000018, 32'hFFFFFFFF, err);
        checkBool(err, 1'b1, "pslverr on unmapped write");
        apbRead(32'h00000018, data, err);
        checkBool(err, 1'b1, "pslverr on unmapped read");
        checkWord(data, 32'd0, "unmapped read data");
        apbWrite(32'h00000108, 32'd5, err);
        checkBool(err, 1'b1, "pslverr on high address write");
        apbWrite(wordT'(`REG_GROUPCNT), 32'h55, err);
        checkBool(err, 1'b1, "pslverr on GROUPCNT write");
        apbRead(wordT'(`REG_GROUPCNT), data, err);
        checkBool(err, 1'b0, "pslverr on GROUPCNT read");
        checkWord(data, cntBefore, "GROUPCNT unchanged");
        apbRead(wordT'(`REG_WAIT), data, err);
        checkWord(data, waitBefore, "WAIT unchanged");
        endTest("apb errors");
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        void'($urandom(32'h41a5fde7));
        clk           = 1'b0;
        rst           = 1'b0;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        stopFetch     = 1'b0;
        predictPc     = '0;
        needDelaySlot = 1'b0;
        flush         = 1'b0;
        correctPc     = '0;
        excOccur      = 1'b0;
        excPc         = '0;
        checkCount    = 0;
        errorCount    = 0;
        testCount     = 0;
        validCount    = 0;
        trackIdx      = groupIdxT'(`START_PC >> 4);

        // four cycles of reset
        step(4);
        rst = 1'b1;
        step(1);

        testResetBoot();
        testPredicted();
        testRedirect();
        testAlignError();
        testBackPressure();
        testApbErrors();

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
